/* design/mem_pkg.sv */
////////////////////////////////////////////////////////////
// memory stage package
// widths, bus commands, cache geometry and shared structs
////////////////////////////////////////////////////////////
package mem_pkg;

  ////////////////////////////////////////////////////////////
  // widths and bus commands
  ////////////////////////////////////////////////////////////
  typedef logic [63:0] addr_t;     // byte address
  typedef logic [63:0] data_t;     // one 64-bit word
  typedef logic [3:0]  mem_tag_t;  // zero means no transaction

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  ////////////////////////////////////////////////////////////
  // geometry and timing
  ////////////////////////////////////////////////////////////
  localparam int OFS_BITS     = 3;                          // byte offset inside a word
  localparam int CACHE_LINES  = 16;                         // one word per line
  localparam int IDX_BITS     = 4;                          // index is addr[6:3]
  localparam int TAG_BITS     = 64 - IDX_BITS - OFS_BITS;   // addr[63:7]
  localparam int MEM_WORDS    = 256;
  localparam int MEM_SEL_BITS = $clog2(MEM_WORDS);          // word select is addr[10:3]
  localparam int LOAD_LATENCY = 4;                          // accept to data return

  typedef logic [TAG_BITS-1:0] cache_tag_t;

  ////////////////////////////////////////////////////////////
  // structs between stages
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic  rd_mem;    // load this cycle
    logic  wr_mem;    // store this cycle
    addr_t rd_addr;   // load address or alu result
    addr_t wr_addr;
    data_t wr_data;
  } mem_req_t;

  // store queue forwarding flags
  typedef struct packed {
    logic  data_valid;      // forwarded word present
    logic  data_not_found;  // an older store address is unknown
    data_t data;
  } sq_fwd_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } fill_t;

  typedef struct packed {
    bus_cmd_e command;
    addr_t    addr;
    data_t    data;
  } dmem_req_t;

  typedef struct packed {
    mem_tag_t response;  // tag handed out at acceptance
    mem_tag_t tag;       // tag of the returning data
    data_t    data;
  } dmem_rsp_t;

endpackage

/* design/dcache.sv */
////////////////////////////////////////////////////////////
// direct-mapped write-through data cache
// one outstanding miss, fills matched by memory tag
////////////////////////////////////////////////////////////
module dcache (
  input  logic                clock,
  input  logic                rst,
  input  logic                rd_en,     // load wants the cache
  input  mem_pkg::addr_t      rd_addr,
  input  logic                wr_en,     // store this cycle
  input  mem_pkg::addr_t      wr_addr,
  input  mem_pkg::data_t      wr_data,
  input  mem_pkg::dmem_rsp_t  dmem_rsp,
  output mem_pkg::data_t      rd_data,
  output logic                rd_valid,  // hit, rd_data usable
  output mem_pkg::fill_t      fill,      // miss return notice
  output mem_pkg::dmem_req_t  dmem_req
);
  import mem_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT_DATA
  } state_e;

  ////////////////////////////////////////////////////////////
  // line storage
  ////////////////////////////////////////////////////////////
  logic [CACHE_LINES-1:0] line_valid;            // cleared by reset
  cache_tag_t             line_tag  [CACHE_LINES];
  data_t                  line_data [CACHE_LINES];

  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;
  logic [IDX_BITS-1:0] fill_idx;
  cache_tag_t          rd_tag;
  cache_tag_t          wr_tag;
  cache_tag_t          fill_tag;

  logic wr_hit;
  logic load_miss;   // miss with no request out yet
  logic bus_load;    // miss actually drives the bus
  logic ld_accept;   // memory took the load
  logic fill_match;  // returning tag is ours

  state_e   state;
  state_e   state_nxt;
  addr_t    miss_addr;  // address of the outstanding miss
  mem_tag_t miss_tag;   // tag memory gave that miss

  // address split
  assign rd_idx   = rd_addr[OFS_BITS +: IDX_BITS];
  assign rd_tag   = rd_addr[OFS_BITS+IDX_BITS +: TAG_BITS];
  assign wr_idx   = wr_addr[OFS_BITS +: IDX_BITS];
  assign wr_tag   = wr_addr[OFS_BITS+IDX_BITS +: TAG_BITS];
  assign fill_idx = miss_addr[OFS_BITS +: IDX_BITS];
  assign fill_tag = miss_addr[OFS_BITS+IDX_BITS +: TAG_BITS];

  // lookup, data comes straight out of the array
  assign rd_valid = rd_en && line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
  assign rd_data  = line_data[rd_idx];
  assign wr_hit   = wr_en && line_valid[wr_idx] && (line_tag[wr_idx] == wr_tag);

  assign load_miss  = (state == IDLE) && rd_en && !rd_valid;
  assign bus_load   = load_miss && !wr_en;          // store owns the bus first
  assign ld_accept  = bus_load && (dmem_rsp.response != '0);
  assign fill_match = (state == WAIT_DATA) && (dmem_rsp.tag == miss_tag);

  ////////////////////////////////////////////////////////////
  // bus command, store priority
  ////////////////////////////////////////////////////////////
  always_comb begin
    dmem_req.command = BUS_NONE;
    dmem_req.addr    = rd_addr;
    dmem_req.data    = '0;
    if (wr_en) begin
      dmem_req.command = BUS_STORE;  // write-through, every store goes out
      dmem_req.addr    = wr_addr;
      dmem_req.data    = wr_data;
    end else if (bus_load) begin
      dmem_req.command = BUS_LOAD;
    end
  end

  // fill notice for the load queue, same cycle as the return
  always_comb begin
    fill.valid = fill_match;
    fill.addr  = miss_addr;
    fill.data  = dmem_rsp.data;
  end

  ////////////////////////////////////////////////////////////
  // miss fsm
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (ld_accept) begin
          state_nxt = WAIT_DATA;
        end
      end
      WAIT_DATA: begin
        if (fill_match) begin
          state_nxt = IDLE;  // next cycle hits
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state    <= IDLE;
      miss_tag <= '0;
    end else begin
      state <= state_nxt;
      if (ld_accept) begin
        miss_tag <= dmem_rsp.response;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ld_accept) begin
      miss_addr <= rd_addr;
    end
  end

  // valid bits
  always_ff @(posedge clock) begin
    if (rst) begin
      line_valid <= '0;
    end else if (fill_match) begin
      line_valid[fill_idx] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clock) begin
    if (fill_match) begin
      line_tag[fill_idx]  <= fill_tag;
      line_data[fill_idx] <= dmem_rsp.data;
    end
    if (wr_hit) begin
      line_data[wr_idx] <= wr_data;  // later store wins over a fill
    end
  end

endmodule

/* design/mem_stage.sv */
////////////////////////////////////////////////////////////
// memory access stage
// store queue gating, result select and stall
////////////////////////////////////////////////////////////
module mem_stage (
  input  logic                clock,
  input  logic                rst,
  input  mem_pkg::mem_req_t   req,       // held by upstream while stall
  input  mem_pkg::sq_fwd_t    sq,        // store queue forwarding
  input  mem_pkg::dmem_rsp_t  dmem_rsp,
  output mem_pkg::data_t      result,    // to writeback
  output logic                stall,
  output mem_pkg::fill_t      fill,
  output mem_pkg::dmem_req_t  dmem_req
);
  import mem_pkg::*;

  logic  cache_rd_en;    // load that the cache must serve
  data_t cache_data;
  logic  cache_valid;

  // no cache read when the queue forwards or an older address is open
  assign cache_rd_en = req.rd_mem && !sq.data_valid && !sq.data_not_found;

  ////////////////////////////////////////////////////////////
  // result and stall
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (!req.rd_mem) begin
      result = req.rd_addr;      // alu result passes through
    end else if (sq.data_valid) begin
      result = sq.data;          // forwarded from the store queue
    end else begin
      result = cache_data;
    end
  end

  // forwarding never stalls, unknown store address always does
  assign stall = req.rd_mem && !sq.data_valid && (sq.data_not_found || !cache_valid);

  dcache dcache_i (
    .clock    (clock),
    .rst      (rst),
    .rd_en    (cache_rd_en),
    .rd_addr  (req.rd_addr),
    .wr_en    (req.wr_mem),
    .wr_addr  (req.wr_addr),
    .wr_data  (req.wr_data),
    .dmem_rsp (dmem_rsp),
    .rd_data  (cache_data),
    .rd_valid (cache_valid),
    .fill     (fill),
    .dmem_req (dmem_req)
  );

endmodule

/* design/dmem.sv */
////////////////////////////////////////////////////////////
// tagged data memory
// fixed latency loads, several in flight
////////////////////////////////////////////////////////////
module dmem (
  input  logic                clock,
  input  logic                rst,
  input  mem_pkg::dmem_req_t  dmem_req,
  output mem_pkg::dmem_rsp_t  dmem_rsp
);
  import mem_pkg::*;

  ////////////////////////////////////////////////////////////
  // storage and request decode
  ////////////////////////////////////////////////////////////
  data_t words [MEM_WORDS] = '{default: '0};  // zeroed for simulation

  logic [MEM_SEL_BITS-1:0] sel;  // word select
  logic                    is_load;
  logic                    is_store;
  mem_tag_t                next_tag;  // tag for the next load

  // return pipeline, stage 0 is newest
  mem_tag_t pipe_tag  [LOAD_LATENCY];
  data_t    pipe_data [LOAD_LATENCY];

  assign sel      = dmem_req.addr[OFS_BITS +: MEM_SEL_BITS];
  assign is_load  = (dmem_req.command == BUS_LOAD);
  assign is_store = (dmem_req.command == BUS_STORE);

  // stores land at acceptance
  always_ff @(posedge clock) begin
    if (is_store) begin
      words[sel] <= dmem_req.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // tag counter
  ////////////////////////////////////////////////////////////
  // counts 1..15, zero is reserved for idle
  always_ff @(posedge clock) begin
    if (rst) begin
      next_tag <= 4'd1;
    end else if (is_load) begin
      if (next_tag == '1) begin
        next_tag <= 4'd1;
      end else begin
        next_tag <= next_tag + 4'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // load return pipeline
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 0; i < LOAD_LATENCY; i++) begin
        pipe_tag[i] <= '0;
      end
    end else begin
      pipe_tag[0] <= is_load ? next_tag : '0;  // bubble carries tag 0
      for (int i = 1; i < LOAD_LATENCY; i++) begin
        pipe_tag[i] <= pipe_tag[i-1];
      end
    end
  end

  // data read at acceptance, so later stores do not leak in
  always_ff @(posedge clock) begin
    pipe_data[0] <= words[sel];
    for (int i = 1; i < LOAD_LATENCY; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  // response is same cycle, data LOAD_LATENCY cycles later
  always_comb begin
    dmem_rsp.response = is_load ? next_tag : '0;  // stores finish at acceptance
    dmem_rsp.tag      = pipe_tag[LOAD_LATENCY-1];
    dmem_rsp.data     = pipe_data[LOAD_LATENCY-1];
  end

endmodule

/* design/mem_top.sv */
////////////////////////////////////////////////////////////
// memory stage top
// stage with cache plus tagged data memory
////////////////////////////////////////////////////////////
module mem_top (
  input  logic                clock,
  input  logic                rst,
  input  mem_pkg::mem_req_t   req,     // load and store request
  input  mem_pkg::sq_fwd_t    sq,      // store queue outputs
  output mem_pkg::data_t      result,
  output logic                stall,
  output mem_pkg::fill_t      fill,    // miss return notice
  output mem_pkg::dmem_req_t  bus      // memory command, also observed
);
  import mem_pkg::*;

  dmem_rsp_t dmem_rsp;  // memory back to the cache

  ////////////////////////////////////////////////////////////
  // stage and memory
  ////////////////////////////////////////////////////////////
  mem_stage mem_stage_i (
    .clock    (clock),
    .rst      (rst),
    .req      (req),
    .sq       (sq),
    .dmem_rsp (dmem_rsp),
    .result   (result),
    .stall    (stall),
    .fill     (fill),
    .dmem_req (bus)
  );

  // one command per cycle, tags back in order
  dmem dmem_i (
    .clock    (clock),
    .rst      (rst),
    .dmem_req (bus),
    .dmem_rsp (dmem_rsp)
  );

endmodule

/* dv/mem_tb.sv */
////////////////////////////////////////////////////////////
// memory stage testbench
// random loads and stores checked against a word model
////////////////////////////////////////////////////////////
module mem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int N_OPS           = 600;
  localparam int MAX_MISS        = LOAD_LATENCY + 3;  // stall bound after the flag clears
  localparam int WATCHDOG_CYCLES = N_OPS * (LOAD_LATENCY + 8) + 16;

  logic      clock = 1'b0;
  logic      rst;
  mem_req_t  req;
  sq_fwd_t   sq;
  data_t     result;
  logic      stall;
  fill_t     fill;
  dmem_req_t bus;

  data_t       model [MEM_WORDS];  // what memory should hold
  logic [63:0] rng_state;
  int          errors;
  int          n_loads;
  int          n_misses;
  int          n_stores;
  int          n_fwd;
  int          n_wait;
  int          n_alu;

  always #4 clock = ~clock;  // 8 ns period

  mem_top dut_i (
    .clock  (clock),
    .rst    (rst),
    .req    (req),
    .sq     (sq),
    .result (result),
    .stall  (stall),
    .fill   (fill),
    .bus    (bus)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [63:0] xorshift64();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // word aligned address inside 2 KB
  // half the picks come from a 32-word pool so lines get reused and aliased
  function automatic addr_t pick_addr(input logic [63:0] r);
    logic [7:0] word;
    word = r[7:0];
    if (r[8]) begin
      word[7:5] = 3'b000;
    end
    return {53'd0, word, 3'd0};
  endfunction

  task automatic show_mismatch(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    errors++;
    $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  ////////////////////////////////////////////////////////////
  // one request from drive to retire
  ////////////////////////////////////////////////////////////
  task automatic run_op();
    logic [63:0] kind;
    mem_req_t    nr;
    sq_fwd_t     ns;
    logic [7:0]  idx;
    data_t       expected;
    int          hold;         // cycles data_not_found stays set
    int          miss_cycles;  // stall cycles after the flag cleared
    int          fill_count;
    int          load_cmds;
    logic        done;
    kind        = xorshift64();
    nr          = '0;
    ns          = '0;
    hold        = 0;
    miss_cycles = 0;
    fill_count  = 0;
    load_cmds   = 0;
    done        = 1'b0;
    nr.rd_addr  = pick_addr(xorshift64());
    case (kind[2:0])
      3'd0, 3'd1, 3'd2: begin
        nr.wr_mem  = 1'b1;
        nr.wr_addr = pick_addr(xorshift64());
        nr.wr_data = xorshift64();
        n_stores++;
      end
      3'd3, 3'd4: begin
        nr.rd_mem = 1'b1;  // plain load that may hit or miss
        n_loads++;
      end
      3'd5: begin
        nr.rd_mem     = 1'b1;
        ns.data_valid = 1'b1;
        ns.data       = xorshift64();
        n_fwd++;
      end
      3'd6: begin
        nr.rd_mem         = 1'b1;
        ns.data_not_found = 1'b1;
        hold              = int'(kind[5:3]) + 1;
        n_wait++;
      end
      default: n_alu++;  // rd_mem low so the address passes through
    endcase
    idx = nr.rd_addr[10:3];

    @(posedge clock);
    req <= nr;
    sq  <= ns;
    while (!done) begin
      @(negedge clock);  // outputs settled mid cycle
      if (hold > 0) begin
        // older store address still open
        if (stall !== 1'b1) show_mismatch("stall", 64'd1, 64'(stall));
        if (bus.command === BUS_LOAD) begin
          note_failure("memory load issued with a store address unknown");
        end
      end else if (stall === 1'b1 && nr.rd_mem && !ns.data_valid) begin
        miss_cycles++;
        if (fill.valid === 1'b1) begin
          fill_count++;
          if (fill.addr !== nr.rd_addr) show_mismatch("fill.addr", nr.rd_addr, fill.addr);
          if (fill.data !== model[idx]) show_mismatch("fill.data", model[idx], fill.data);
        end
        if (bus.command === BUS_LOAD) begin
          load_cmds++;
          if (bus.addr !== nr.rd_addr) show_mismatch("bus.addr", nr.rd_addr, bus.addr);
        end
        if (miss_cycles > MAX_MISS) begin
          note_failure($sformatf("load at %h still stalled after %0d cycles", nr.rd_addr,
                                 miss_cycles));
          done = 1'b1;
        end
      end else begin
        // retire cycle
        if (stall !== 1'b0) show_mismatch("stall", 64'd0, 64'(stall));
        if (fill.valid !== 1'b0) note_failure("fill.valid high in the cycle the request retired");
        if (!nr.rd_mem) begin
          expected = nr.rd_addr;
        end else if (ns.data_valid) begin
          expected = ns.data;
        end else begin
          expected = model[idx];
        end
        if (result !== expected) show_mismatch("result", expected, result);
        if (nr.wr_mem) begin
          if (bus.command !== BUS_STORE) begin
            show_mismatch("bus.command", 64'(BUS_STORE), 64'(bus.command));
          end
          if (bus.addr !== nr.wr_addr) show_mismatch("bus.addr", nr.wr_addr, bus.addr);
          if (bus.data !== nr.wr_data) show_mismatch("bus.data", nr.wr_data, bus.data);
          model[nr.wr_addr[10:3]] = nr.wr_data;  // memory takes it at this edge
        end else if (bus.command !== BUS_NONE) begin
          show_mismatch("bus.command", 64'(BUS_NONE), 64'(bus.command));
        end
        if (miss_cycles > 0) begin
          n_misses++;
          if (fill_count != 1) begin
            note_failure($sformatf("fill pulsed %0d times on one miss", fill_count));
          end
          if (load_cmds != 1) begin
            note_failure($sformatf("%0d memory loads issued for one miss", load_cmds));
          end
        end
        done = 1'b1;
      end
      if (!done) begin
        @(posedge clock);
        if (hold > 0) begin
          hold--;
          if (hold == 0) begin
            sq.data_not_found <= 1'b0;  // store queue resolved the address
          end
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rng_state = 64'd72;
    errors    = 0;
    n_loads   = 0;
    n_misses  = 0;
    n_stores  = 0;
    n_fwd     = 0;
    n_wait    = 0;
    n_alu     = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = '0;  // dmem starts zeroed
    end
    rst = 1'b1;
    req = '0;
    sq  = '0;
    repeat (3) @(posedge clock);
    rst <= 1'b0;
    // quiet bus until the first request
    repeat (3) begin
      @(negedge clock);
      if (bus.command !== BUS_NONE) begin
        show_mismatch("bus.command", 64'(BUS_NONE), 64'(bus.command));
      end
      if (fill.valid !== 1'b0) show_mismatch("fill.valid", 64'd0, 64'(fill.valid));
    end
    for (int n = 0; n < N_OPS; n++) begin
      run_op();
    end
    @(posedge clock);
    req <= '0;
    sq  <= '0;
    @(negedge clock);
    $display("errors %0d loads %0d misses %0d stores %0d forwarded %0d waited %0d alu %0d",
             errors, n_loads, n_misses, n_stores, n_fwd, n_wait, n_alu);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog sized from the request count
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("errors %0d", errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* list.f */
design/mem_pkg.sv
design/dcache.sv
design/mem_stage.sv
design/dmem.sv
design/mem_top.sv
dv/mem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the memory stage testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module mem_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vmem_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
